// File: video_dac.f
source/color_pkg.sv
source/video_mode_pkg.sv
source/palette_ram.sv
source/colour_fetch.sv
source/channel_pwm.sv
source/dac_output.sv
source/video_out_top.sv
test/tb_video_dac.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_video_dac
FLIST     = video_dac.f
OBJDIR    = obj_dir

SIM  = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)

// File: test/video_dac_testdata.txt
# W addr colour: palette write, 15-bit colour in hex, red field on top
# P vga_on hires nib_sel palsel blank vga_line tv_byte vga_byte, all hex
W 12 5567
W 3c 7f3c
W a7 24d2
W 5a 7fff
W 53 0e8e
W 9c 6037
W 96 3745
P 1 0 0 0 0 0 00 12
P 1 0 0 0 0 1 3c a7
P 1 1 0 5 0 0 00 a3
P 1 1 1 5 0 1 00 a3
P 0 0 0 0 0 1 3c 00
P 0 1 0 9 0 0 c6 ff
P 0 1 1 9 0 1 c6 ff
P 1 0 0 0 1 0 00 12
P 0 1 1 9 1 0 c6 00
P 0 0 0 0 0 0 5a 12
W 12 4210
P 1 0 0 0 0 1 00 12
P 1 1 0 5 0 1 00 ac

// File: test/tb_video_dac.sv
// Testbench for the video DAC that runs the palette writes and pixels listed in the data file
`timescale 1ns/1ps
`default_nettype none

module tb_video_dac
	import color_pkg::*;
	import video_mode_pkg::*;
();

	localparam string DATA_FILE = "test/video_dac_testdata.txt";
	localparam int CLK_PERIOD = 40;
	localparam int HS_LIMIT = 8;
	// dither pattern per fine level indexed by phase*2 + half
	localparam logic [7:0] PATTERNS [8] = '{
		8'h00, 8'h01, 8'h41, 8'h45,
		8'ha5, 8'ha7, 8'hd7, 8'hdf
	};

	logic                clk;
	logic                rst;
	logic                c3;
	logic                vga_on;
	logic                vga_line;
	logic [PIX_W-1:0]    tv_pix;
	logic [PIX_W-1:0]    vga_pix;
	logic [1:0]          nib_sel;
	logic                tv_hires;
	logic                vga_hires;
	logic                tv_blank;
	logic                vga_blank;
	logic [PALSEL_W-1:0] palsel;
	logic                cram_req;
	logic [CRAM_AW-1:0]  cram_addr;
	logic [COLOR_W-1:0]  cram_data;
	logic                cram_ack;
	logic [COARSE_W-1:0] vred;
	logic [COARSE_W-1:0] vgrn;
	logic [COARSE_W-1:0] vblu;

	logic [COLOR_W-1:0] pal_model [CRAM_DEPTH];
	logic [1:0]         ph_cnt;
	string              ops [$];
	int                 n_errors;
	int                 n_tests;
	integer             seed;
	logic               loaded;

	video_out_top dut (
		.clk       (clk),
		.rst       (rst),
		.c3        (c3),
		.vga_on    (vga_on),
		.vga_line  (vga_line),
		.tv_pix    (tv_pix),
		.vga_pix   (vga_pix),
		.nib_sel   (nib_sel),
		.tv_hires  (tv_hires),
		.vga_hires (vga_hires),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.palsel    (palsel),
		.cram_req  (cram_req),
		.cram_addr (cram_addr),
		.cram_data (cram_data),
		.cram_ack  (cram_ack),
		.vred      (vred),
		.vgrn      (vgrn),
		.vblu      (vblu)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// own copy of the phase counter that runs freely from reset
	always @(posedge clk)
	begin
		if (rst)
			ph_cnt <= 2'd0;
		else
			ph_cnt <= ph_cnt + 2'd1;
	end

	// field 2 is red and field 0 is blue
	// half 1 is the level shown while clk is high
	function automatic logic [1:0] dither_level(input logic [COLOR_W-1:0] word, input int field,
		input logic [1:0] ph, input logic half);
		logic [CHAN_W-1:0] chan;
		logic [7:0]        pat;
		chan = word[field*CHAN_W +: CHAN_W];
		pat = PATTERNS[chan[2:0]];
		if (pat[{ph, half}] && chan[4:3] != 2'd3)
			return chan[4:3] + 2'd1;
		return chan[4:3];
	endfunction

	task automatic check_level(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			n_errors++;
		end
	endtask

	task automatic idle_cycles();
		logic [31:0] r;
		r = $random(seed);
		repeat (r[1:0])
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic wait_ack(input logic level);
		int waited;
		waited = 0;
		do
		begin
			@(posedge clk);
			#2;
			waited++;
		end while (cram_ack !== level && waited < HS_LIMIT);
	endtask

	task automatic write_palette(input logic [CRAM_AW-1:0] addr, input logic [COLOR_W-1:0] data);
		int start_errs;
		start_errs = n_errors;
		if (cram_ack !== 1'b0)
		begin
			$display("ERROR at %0t ns: cram_ack expected 0, got %b", $time, cram_ack);
			n_errors++;
		end
		idle_cycles();
		cram_addr = addr;
		cram_data = data;
		cram_req = 1'b1;
		wait_ack(1'b1);
		if (cram_ack !== 1'b1)
		begin
			$display("write to %h hung: cram_ack never rose after cram_req", addr);
			n_errors++;
		end
		idle_cycles();
		if (cram_ack !== 1'b1)
		begin
			$display("write to %h: cram_ack dropped while cram_req was still high", addr);
			n_errors++;
		end
		cram_req = 1'b0;
		wait_ack(1'b0);
		if (cram_ack !== 1'b0)
		begin
			$display("write to %h hung: cram_ack stayed high after cram_req fell", addr);
			n_errors++;
		end
		pal_model[addr] = data;
		n_tests++;
		$display("test %0d: palette write %h = %h %s", n_tests, addr, data,
			n_errors == start_errs ? "ok" : "FAILED");
	endtask

	task automatic show_pixel(input string op);
		logic [31:0]        src;
		logic [31:0]        hires;
		logic [31:0]        nsel;
		logic [31:0]        psel;
		logic [31:0]        blank;
		logic [31:0]        line;
		logic [31:0]        tvb;
		logic [31:0]        vgab;
		logic [7:0]         pix;
		logic [7:0]         idx;
		logic [COLOR_W-1:0] word;
		logic [1:0]         ph;
		int                 n;
		int                 start_errs;
		start_errs = n_errors;
		n = $sscanf(op.substr(1, op.len() - 1), "%h %h %h %h %h %h %h %h",
			src, hires, nsel, psel, blank, line, tvb, vgab);
		if (n != 8)
		begin
			$display("pixel line could not be parsed: %s", op);
			n_errors++;
			return;
		end
		pix = src[0] ? vgab[7:0] : tvb[7:0];
		if (hires[0])
			idx = {psel[3:0], nsel[0] ? pix[3:0] : pix[7:4]};
		else
			idx = pix;
		word = blank[0] ? '0 : pal_model[idx];

		// TV renderer presents its byte on c3 one edge ahead of the pixel
		tv_pix = tvb[7:0];
		c3 = 1'b1;
		@(posedge clk);
		#2;
		// the latched byte has to hold once the renderer moves on
		c3 = 1'b0;
		tv_pix = ~tvb[7:0];
		// the source that is not selected gets the opposite mode bits
		vga_on = src[0];
		vga_line = line[0];
		vga_hires = src[0] ? hires[0] : !hires[0];
		tv_hires = !vga_hires;
		vga_blank = src[0] ? blank[0] : !blank[0];
		tv_blank = !vga_blank;
		nib_sel = src[0] ? {!nsel[0], nsel[0]} : {nsel[0], !nsel[0]};
		palsel = psel[3:0];
		vga_pix = vgab[7:0];
		// sampled at the next edge, levels registered two edges after that
		repeat (3) @(posedge clk);

		#10;
		// phase as it stood before the last edge
		ph = ph_cnt - 2'd1;
		if (src[0])
			ph[1] = line[0];
		check_level("vred", dither_level(word, 2, ph, 1'b1), vred);
		check_level("vgrn", dither_level(word, 1, ph, 1'b1), vgrn);
		check_level("vblu", dither_level(word, 0, ph, 1'b1), vblu);
		#20;
		check_level("vred", dither_level(word, 2, ph, 1'b0), vred);
		check_level("vgrn", dither_level(word, 1, ph, 1'b0), vgrn);
		check_level("vblu", dither_level(word, 0, ph, 1'b0), vblu);
		@(posedge clk);
		#2;
		n_tests++;
		$display("test %0d: %s %s pixel, index %h, phase %0d%s %s", n_tests,
			src[0] ? "VGA" : "TV", hires[0] ? "hires" : "lores", idx, ph,
			blank[0] ? ", blanked" : "", n_errors == start_errs ? "ok" : "FAILED");
	endtask

	initial
	begin
		int          fd;
		int          n;
		string       line;
		logic [31:0] addr;
		logic [31:0] data;
		rst = 1'b1;
		c3 = 1'b0;
		vga_on = 1'b0;
		vga_line = 1'b0;
		tv_pix = '0;
		vga_pix = '0;
		nib_sel = '0;
		tv_hires = 1'b0;
		vga_hires = 1'b0;
		tv_blank = 1'b1;
		vga_blank = 1'b1;
		palsel = '0;
		cram_req = 1'b0;
		cram_addr = '0;
		cram_data = '0;
		seed = 32'h8d52;
		n_errors = 0;
		n_tests = 0;
		loaded = 1'b0;

		fd = $fopen(DATA_FILE, "r");
		if (fd == 0)
		begin
			$display("data file %s could not be opened", DATA_FILE);
			n_errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				if (n > 0 && (line[0] == "W" || line[0] == "P"))
					ops.push_back(line);
			end
			$fclose(fd);
		end
		loaded = 1'b1;

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		foreach (ops[i])
		begin
			line = ops[i];
			if (line[0] == "W")
			begin
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, data);
				if (n != 2)
				begin
					$display("write line could not be parsed: %s", line);
					n_errors++;
				end
				else
					write_palette(addr[CRAM_AW-1:0], data[COLOR_W-1:0]);
			end
			else
				show_pixel(line);
		end

		$display("%0d tests run, %0d failed checks", n_tests, n_errors);
		if (n_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// limit scales with the number of operations read
	initial
	begin
		wait (loaded);
		#((ops.size() * 24 + 100) * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", ops.size() * 24 + 100);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/video_out_top.sv
// Video DAC top level, pixel byte in and dithered 2-bit RGB out, CPU palette writes
`default_nettype none
`timescale 1ns/1ps

module video_out_top
	import color_pkg::*;
	import video_mode_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                c3,
	input  logic                vga_on,
	input  logic                vga_line,
	input  logic [PIX_W-1:0]    tv_pix,
	input  logic [PIX_W-1:0]    vga_pix,
	input  logic [1:0]          nib_sel,
	input  logic                tv_hires,
	input  logic                vga_hires,
	input  logic                tv_blank,
	input  logic                vga_blank,
	input  logic [PALSEL_W-1:0] palsel,
	input  logic                cram_req,
	input  logic [CRAM_AW-1:0]  cram_addr,
	input  logic [COLOR_W-1:0]  cram_data,
	output logic                cram_ack,
	output logic [COARSE_W-1:0] vred,
	output logic [COARSE_W-1:0] vgrn,
	output logic [COARSE_W-1:0] vblu
);

	logic [COLOR_W-1:0]           color;
	logic [PHASE_W-1:0]           phase;
	logic [NUM_CHAN*COARSE_W-1:0] lo_levels;
	logic [NUM_CHAN*COARSE_W-1:0] hi_levels;

	colour_fetch u_fetch (
		.clk       (clk),
		.rst       (rst),
		.c3        (c3),
		.vga_on    (vga_on),
		.tv_pix    (tv_pix),
		.vga_pix   (vga_pix),
		.nib_sel   (nib_sel),
		.tv_hires  (tv_hires),
		.vga_hires (vga_hires),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.palsel    (palsel),
		.cram_req  (cram_req),
		.cram_addr (cram_addr),
		.cram_data (cram_data),
		.cram_ack  (cram_ack),
		.color     (color)
	);

	// channel 0 is blue at the bottom of the word, channel 2 is red
	for (genvar ch = 0; ch < NUM_CHAN; ch++)
	begin : g_chan
		channel_pwm u_pwm (
			.clk    (clk),
			.rst    (rst),
			.coarse (color[ch*CHAN_W+FINE_W +: COARSE_W]),
			.fine   (color[ch*CHAN_W +: FINE_W]),
			.phase  (phase),
			.level0 (lo_levels[ch*COARSE_W +: COARSE_W]),
			.level1 (hi_levels[ch*COARSE_W +: COARSE_W])
		);
	end

	dac_output u_dac (
		.clk       (clk),
		.rst       (rst),
		.vga_on    (vga_on),
		.vga_line  (vga_line),
		.lo_levels (lo_levels),
		.hi_levels (hi_levels),
		.phase     (phase),
		.vred      (vred),
		.vgrn      (vgrn),
		.vblu      (vblu)
	);

endmodule

`default_nettype wire

// File: source/dac_output.sv
// PWM phase generation and the half-clock output mux feeding the video DAC pins
`default_nettype none
`timescale 1ns/1ps

module dac_output
	import color_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         vga_on,
	input  logic                         vga_line,
	input  logic [NUM_CHAN*COARSE_W-1:0] lo_levels,
	input  logic [NUM_CHAN*COARSE_W-1:0] hi_levels,
	output logic [PHASE_W-1:0]           phase,
	output logic [COARSE_W-1:0]          vred,
	output logic [COARSE_W-1:0]          vgrn,
	output logic [COARSE_W-1:0]          vblu
);

	logic [PHASE_W-1:0]           ph_cnt;
	logic [NUM_CHAN*COARSE_W-1:0] dac_word;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ph_cnt <= '0;
		end
		else
		begin
			ph_cnt <= ph_cnt + 1'b1;
		end
	end

	// VGA lines alternate the upper phase bit instead of the counter
	assign phase = {vga_on ? vga_line : ph_cnt[1], ph_cnt[0]};

	// second level goes out while clk is high
	assign dac_word = clk ? hi_levels : lo_levels;

	assign vred = dac_word[2*COARSE_W +: COARSE_W];
	assign vgrn = dac_word[1*COARSE_W +: COARSE_W];
	assign vblu = dac_word[0*COARSE_W +: COARSE_W];

endmodule

`default_nettype wire

// File: source/channel_pwm.sv
// Dithers one colour channel into two DAC levels, one for each clock half
`default_nettype none
`timescale 1ns/1ps

module channel_pwm
	import color_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic [COARSE_W-1:0] coarse,
	input  logic [FINE_W-1:0]   fine,
	input  logic [PHASE_W-1:0]  phase,
	output logic [COARSE_W-1:0] level0,
	output logic [COARSE_W-1:0] level1
);

	logic [PWM_STEPS-1:0] pattern;
	logic                 at_top;
	logic                 bump0;
	logic                 bump1;

	assign pattern = PWM_TABLE[fine];
	// full coarse level has no headroom to step up
	assign at_top = &coarse;
	assign bump0 = pattern[{phase, 1'b0}] && !at_top;
	assign bump1 = pattern[{phase, 1'b1}] && !at_top;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			level0 <= '0;
			level1 <= '0;
		end
		else
		begin
			level0 <= bump0 ? coarse + 1'b1 : coarse;
			level1 <= bump1 ? coarse + 1'b1 : coarse;
		end
	end

endmodule

`default_nettype wire

// File: source/colour_fetch.sv
// Chooses the TV or VGA pixel, forms the palette index and reads the colour word
`default_nettype none
`timescale 1ns/1ps

module colour_fetch
	import color_pkg::*;
	import video_mode_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                c3,
	input  logic                vga_on,
	input  logic [PIX_W-1:0]    tv_pix,
	input  logic [PIX_W-1:0]    vga_pix,
	input  logic [1:0]          nib_sel,
	input  logic                tv_hires,
	input  logic                vga_hires,
	input  logic                tv_blank,
	input  logic                vga_blank,
	input  logic [PALSEL_W-1:0] palsel,
	input  logic                cram_req,
	input  logic [CRAM_AW-1:0]  cram_addr,
	input  logic [COLOR_W-1:0]  cram_data,
	output logic                cram_ack,
	output logic [COLOR_W-1:0]  color
);

	logic [PIX_W-1:0]   tv_byte;
	pixel_byte_u        pix;
	logic               hires;
	logic               blank;
	logic               low_nib;
	logic [CRAM_AW-1:0] index;
	logic [CRAM_AW-1:0] rd_addr;
	logic               blank_q;
	logic               blank_qq;
	logic [COLOR_W-1:0] rd_data;

	// TV renderer only presents a new byte on c3
	always_ff @(posedge clk)
	begin
		if (c3)
		begin
			tv_byte <= tv_pix;
		end
	end

	always_comb
	begin
		pix.index = vga_on ? vga_pix : tv_byte;
		hires     = vga_on ? vga_hires : tv_hires;
		blank     = vga_on ? vga_blank : tv_blank;
		low_nib   = vga_on ? nib_sel[0] : nib_sel[1];
		// hires pixel sits under the palette select bits
		if (hires)
			index = {palsel, low_nib ? pix.nib[0] : pix.nib[1]};
		else
			index = pix.index;
	end

	always_ff @(posedge clk)
	begin
		rd_addr <= index;
	end

	// blank follows the index and then the RAM read
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			blank_q  <= 1'b1;
			blank_qq <= 1'b1;
		end
		else
		begin
			blank_q  <= blank;
			blank_qq <= blank_q;
		end
	end

	palette_ram u_cram (
		.clk       (clk),
		.rst       (rst),
		.cram_req  (cram_req),
		.cram_addr (cram_addr),
		.cram_data (cram_data),
		.cram_ack  (cram_ack),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	assign color = blank_qq ? '0 : rd_data;

endmodule

`default_nettype wire

// File: source/palette_ram.sv
// Colour RAM with one registered video read per cycle and a req/ack CPU write port
`default_nettype none
`timescale 1ns/1ps

module palette_ram
	import color_pkg::*;
	import video_mode_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	// CPU write side
	input  logic               cram_req,
	input  logic [CRAM_AW-1:0] cram_addr,
	input  logic [COLOR_W-1:0] cram_data,
	output logic               cram_ack,
	// video read side
	input  logic [CRAM_AW-1:0] rd_addr,
	output logic [COLOR_W-1:0] rd_data
);

	logic [COLOR_W-1:0] mem [0:CRAM_DEPTH-1];
	logic               wr_en;

	// write once per request, on the edge that raises ack
	assign wr_en = cram_req && !cram_ack;

	// handshake state is just the ack bit
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cram_ack <= 1'b0;
		end
		else if (wr_en)
		begin
			cram_ack <= 1'b1;
		end
		else if (!cram_req)
		begin
			// writer has let go, allow the next request
			cram_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[cram_addr] <= cram_data;
		end
	end

	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: source/video_mode_pkg.sv
// Pixel byte formats and colour RAM addressing, imported by the fetch stage and the RAM
`default_nettype none

package video_mode_pkg;

	localparam int PIX_W = 8;
	localparam int NIB_W = 4;
	// palette select sits above the nibble in hires
	localparam int PALSEL_W = 4;
	localparam int CRAM_AW = 8;
	localparam int CRAM_DEPTH = 2 ** CRAM_AW;

	// nibbles per pixel byte in hires
	localparam int NIB_PER_BYTE = PIX_W / NIB_W;

	// one pixel byte, read whole in lores or as two pixels in hires
	typedef union packed {
		logic [PIX_W-1:0] index;
		// nib[1] is the high nibble, nib[0] the low one
		logic [NIB_PER_BYTE-1:0][NIB_W-1:0] nib;
	} pixel_byte_u;

endpackage

`default_nettype wire

// File: source/color_pkg.sv
// Colour word layout and PWM dither patterns, imported by the channel and DAC stages
`default_nettype none

package color_pkg;

	// coarse level, also the DAC width
	localparam int COARSE_W = 2;
	// fine dither level
	localparam int FINE_W = 3;
	localparam int CHAN_W = COARSE_W + FINE_W;
	localparam int NUM_CHAN = 3;
	// red on top, then green, then blue
	localparam int COLOR_W = NUM_CHAN * CHAN_W;

	localparam int PWM_STEPS = 8;
	// two clock halves per step pair, so the phase picks one of four pairs
	localparam int PHASE_W = 2;

	// one pattern per fine level, bit index is phase*2 + half
	localparam logic [PWM_STEPS-1:0] PWM_TABLE [0:PWM_STEPS-1] = '{
		8'b00000000,
		8'b00000001,
		8'b01000001,
		8'b01000101,
		8'b10100101,
		8'b10100111,
		8'b11010111,
		8'b11011111
	};

endpackage

`default_nettype wire
